/* cpu20_alu.sv */
// Combinational ALU for logic, shift, rotate, swap, inc/dec and compares
// Full or half word, flag results with an update mask
`include "cpu20_macros.svh"

module cpu20_alu (
    cpu20_exec_if.alu ex
);

    localparam int WW = `CPU20_WORD_W;
    localparam int HW = `CPU20_HALF_W;

    cpu20_pkg::word_t wmask;    // Active width mask
    cpu20_pkg::word_t am, bm;   // Operands trimmed to active width
    logic             a_msb;    // Top bit of active width
    logic             a_eq_b, a_gt_b, a_lt_b;
    cpu20_pkg::word_t rotr_a, rotl_a;

    assign wmask = ex.half ? cpu20_pkg::word_t'({HW{1'b1}}) : '1;
    assign am    = ex.a & wmask;
    assign bm    = ex.b & wmask;
    assign a_msb = ex.half ? ex.a[HW-1] : ex.a[WW-1];

    // Unsigned compares
    assign a_eq_b = (am == bm);
    assign a_gt_b = (am > bm);
    assign a_lt_b = (am < bm);

    // Rotates stay inside the active width
    assign rotr_a = ex.half ? cpu20_pkg::word_t'({am[0], am[HW-1:1]})
                            : {am[0], am[WW-1:1]};
    assign rotl_a = ex.half ? cpu20_pkg::word_t'({am[HW-2:0], am[HW-1]})
                            : {am[WW-2:0], am[WW-1]};

    always_comb begin
        ex.res1      = '0;
        ex.res2      = '0;
        ex.flags_new = '0;
        ex.flag_mask = '0;   // Empty mask for unkept ops
        case (ex.op)
            cpu20_pkg::NOT_OP: begin
                ex.res1           = ~am & wmask;
                ex.flags_new.zero = ~|ex.res1;
                ex.flag_mask.zero = 1'b1;
            end
            cpu20_pkg::AND_OP, cpu20_pkg::OR_OP, cpu20_pkg::XOR_OP: begin
                if (ex.op == cpu20_pkg::AND_OP)
                    ex.res1 = am & bm;
                else if (ex.op == cpu20_pkg::OR_OP)
                    ex.res1 = am | bm;
                else
                    ex.res1 = am ^ bm;
                ex.flags_new.zero = ~|ex.res1;
                ex.flag_mask.zero = 1'b1;
            end
            cpu20_pkg::SHFTR_OP: begin
                ex.res1            = am >> 1;   // Zero fill
                ex.flags_new.carry = am[0];     // Bit shifted out
                ex.flags_new.zero  = ~|ex.res1;
                ex.flag_mask.zero  = 1'b1;
                ex.flag_mask.carry = 1'b1;
            end
            cpu20_pkg::SHFTL_OP: begin
                ex.res1            = (am << 1) & wmask;
                ex.flags_new.carry = a_msb;
                ex.flags_new.zero  = ~|ex.res1;
                ex.flag_mask.zero  = 1'b1;
                ex.flag_mask.carry = 1'b1;
            end
            cpu20_pkg::ROTR_OP: ex.res1 = rotr_a;   // No flags
            cpu20_pkg::ROTL_OP: ex.res1 = rotl_a;
            cpu20_pkg::SWAP_OP: begin
                ex.res1 = bm;   // To dst1
                ex.res2 = am;   // To dst2
            end
            cpu20_pkg::INC_OP: begin
                ex.res1            = (am + cpu20_pkg::word_t'(1)) & wmask;
                ex.flags_new.carry = (am == wmask);   // Wraps to zero
                ex.flags_new.zero  = ~|ex.res1;
                ex.flag_mask.zero  = 1'b1;
                ex.flag_mask.carry = 1'b1;
            end
            cpu20_pkg::DEC_OP: begin
                ex.res1            = (am - cpu20_pkg::word_t'(1)) & wmask;
                ex.flags_new.carry = (am == '0);      // Wraps to all ones
                ex.flags_new.zero  = ~|ex.res1;
                ex.flag_mask.zero  = 1'b1;
                ex.flag_mask.carry = 1'b1;
            end
            cpu20_pkg::EQ_OP: begin
                ex.flags_new.zero = a_eq_b;
                ex.flag_mask.zero = 1'b1;
            end
            cpu20_pkg::GT_OP, cpu20_pkg::LT_OP: begin
                ex.flags_new.sign = (ex.op == cpu20_pkg::GT_OP) ? a_gt_b : a_lt_b;
                ex.flag_mask.sign = 1'b1;
            end
            cpu20_pkg::GET_OP, cpu20_pkg::LET_OP: begin
                // Strict compare in sign, equality in zero
                ex.flags_new.sign = (ex.op == cpu20_pkg::GET_OP) ? a_gt_b : a_lt_b;
                ex.flags_new.zero = a_eq_b;
                ex.flag_mask.sign = 1'b1;
                ex.flag_mask.zero = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* cpu20_core.f */
+incdir+.
cpu20_pkg.sv
cpu20_exec_if.sv
cpu20_sequencer.sv
cpu20_regfile.sv
cpu20_alu.sv
cpu20_status.sv
cpu20_core.sv
tb_cpu20_core.sv

/* cpu20_core.sv */
// cpu20 execution core top level
// Sequencer, register file, ALU and status block with host load and debug ports
`include "cpu20_macros.svh"

module cpu20_core (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`CPU20_WORD_W-1:0]      instruction,
    input  logic                          load,
    input  logic [`CPU20_REG_ADDR_W-1:0]  load_addr,
    input  logic [`CPU20_WORD_W-1:0]      load_data,
    input  logic [`CPU20_REG_ADDR_W-1:0]  dbg_addr,
    output logic [`CPU20_WORD_W-1:0]      dbg_data,
    output logic                          fetch_enable,
    output logic                          decode_enable,
    output logic                          execute_enable,
    output logic                          write_back_enable,
    output logic                          zero_flag,
    output logic                          sign_flag,
    output logic                          carry_flag,
    output logic                          trap_flag
);

    cpu20_pkg::reg_addr_t rd_addr1, rd_addr2, wr_addr1, wr_addr2;
    cpu20_pkg::word_t     rd_data1, rd_data2, wr_data1, wr_data2;
    logic                 we1, we2;
    logic                 flag_we, trap_set;
    cpu20_pkg::flags_t    flag_val, flag_mask, flags;

    cpu20_exec_if ex ();   // Sequencer to ALU bundle

    cpu20_sequencer u_seq (
        .clk, .reset, .instruction,
        .trap              (trap_flag),
        .rd_addr1, .rd_addr2, .rd_data1, .rd_data2,
        .ex                (ex.seq),
        .we1, .we2, .wr_addr1, .wr_addr2, .wr_data1, .wr_data2,
        .flag_we, .flag_val, .flag_mask, .trap_set,
        .fetch_enable, .decode_enable, .execute_enable, .write_back_enable
    );

    cpu20_regfile u_regs (
        .clk, .reset,
        .rd_addr1, .rd_addr2, .rd_data1, .rd_data2,
        .we1, .wr_addr1, .wr_data1, .we2, .wr_addr2, .wr_data2,
        .load, .load_addr, .load_data,
        .load_allow        (fetch_enable),   // Host writes only in FETCH
        .dbg_addr, .dbg_data
    );

    cpu20_alu u_alu (.ex(ex.alu));

    cpu20_status u_status (
        .clk, .reset, .flag_we, .flag_val, .flag_mask, .trap_set,
        .flags, .trap(trap_flag)
    );

    // Flag bits out to pins
    assign zero_flag  = flags.zero;
    assign sign_flag  = flags.sign;
    assign carry_flag = flags.carry;

endmodule

/* cpu20_exec_if.sv */
// Execute-stage bundle between sequencer and ALU
// Operands and mode out, results, flags and flag mask back

interface cpu20_exec_if;

    cpu20_pkg::opcode_t op;         // Registered opcode
    logic               half;       // 1 = half word mode
    cpu20_pkg::word_t   a;          // Operand from src1
    cpu20_pkg::word_t   b;          // Operand from src2

    cpu20_pkg::word_t   res1;       // Result for dst1
    cpu20_pkg::word_t   res2;       // Result for dst2, SWAP only
    cpu20_pkg::flags_t  flags_new;  // Candidate flag values
    cpu20_pkg::flags_t  flag_mask;  // Flags this op updates

    // Sequencer side, sampled at end of EXECUTE
    modport seq (
        output op,
        output half,
        output a,
        output b,
        input  res1,
        input  res2,
        input  flags_new,
        input  flag_mask
    );

    // Purely combinational ALU side
    modport alu (
        input  op,
        input  half,
        input  a,
        input  b,
        output res1,
        output res2,
        output flags_new,
        output flag_mask
    );

endinterface

/* cpu20_macros.svh */
// Width, register count and instruction field constants for the cpu20 core
`ifndef CPU20_MACROS_SVH
`define CPU20_MACROS_SVH

// Datapath widths
`define CPU20_WORD_W      20  // Full word
`define CPU20_HALF_W      10  // Half word, low bits only
`define CPU20_OPCODE_W    6
`define CPU20_REG_ADDR_W  3

// Six general registers, addresses 6 and 7 unmapped
`define CPU20_NUM_REGS    6

// Instruction layout
// | opcode | src1 | src2 | dst1 | dst2 | mode | spare |
//   19:14    13:11  10:8   7:5    4:2    1      0
`define CPU20_OPC_LSB     14
`define CPU20_SRC1_LSB    11
`define CPU20_SRC2_LSB    8
`define CPU20_DST1_LSB    5
`define CPU20_DST2_LSB    2
`define CPU20_MODE_BIT    1   // 1 selects half word

`endif

/* cpu20_pkg.sv */
// Shared types for the cpu20 core
// Data word, register address, opcodes, stages and status flags
`include "cpu20_macros.svh"

package cpu20_pkg;

    typedef logic [`CPU20_WORD_W-1:0]     word_t;
    typedef logic [`CPU20_REG_ADDR_W-1:0] reg_addr_t;

    // Full reference encoding, unkept ops decode as NOP
    typedef enum logic [`CPU20_OPCODE_W-1:0] {
        TRAP_OP  = 6'h00, NOP_OP   = 6'h01, JMP_OP   = 6'h02, JMPZ_OP  = 6'h03,
        JMPS_OP  = 6'h04, JMPZS_OP = 6'h05, LSTAT_OP = 6'h06, XSTAT_OP = 6'h07,
        NOT_OP   = 6'h08, AND_OP   = 6'h09, OR_OP    = 6'h0A, XOR_OP   = 6'h0B,
        SHFTR_OP = 6'h0C, SHFTL_OP = 6'h0D, ROTR_OP  = 6'h0E, ROTL_OP  = 6'h0F,
        SWAP_OP  = 6'h10, INC_OP   = 6'h11, DEC_OP   = 6'h12, ADD_OP   = 6'h13,
        ADDC_OP  = 6'h14, SUB_OP   = 6'h15, SUBC_OP  = 6'h16, EQ_OP    = 6'h17,
        GT_OP    = 6'h18, LT_OP    = 6'h19, GET_OP   = 6'h1A, LET_OP   = 6'h1B
    } opcode_t;

    // Stage sequencer states
    typedef enum logic [1:0] {
        FETCH_ST      = 2'd0,
        DECODE_ST     = 2'd1,
        EXECUTE_ST    = 2'd2,
        WRITE_BACK_ST = 2'd3
    } stage_t;

    // Status flags, also used as an update mask
    typedef struct packed {
        logic zero;
        logic sign;
        logic carry;
    } flags_t;

endpackage

/* cpu20_regfile.sv */
// Six general registers, two read and two write ports
// Host load port gated to FETCH, debug read port
`include "cpu20_macros.svh"

module cpu20_regfile (
    input  logic                  clk,
    input  logic                  reset,
    input  cpu20_pkg::reg_addr_t  rd_addr1,
    input  cpu20_pkg::reg_addr_t  rd_addr2,
    output cpu20_pkg::word_t      rd_data1,
    output cpu20_pkg::word_t      rd_data2,
    input  logic                  we1,
    input  cpu20_pkg::reg_addr_t  wr_addr1,
    input  cpu20_pkg::word_t      wr_data1,
    input  logic                  we2,
    input  cpu20_pkg::reg_addr_t  wr_addr2,
    input  cpu20_pkg::word_t      wr_data2,
    input  logic                  load,
    input  cpu20_pkg::reg_addr_t  load_addr,
    input  cpu20_pkg::word_t      load_data,
    input  logic                  load_allow,   // Only in FETCH
    input  cpu20_pkg::reg_addr_t  dbg_addr,
    output cpu20_pkg::word_t      dbg_data
);

    cpu20_pkg::word_t regs [`CPU20_NUM_REGS];

    // Unmapped addresses read as zero
    function automatic cpu20_pkg::word_t rd(input cpu20_pkg::reg_addr_t addr);
        return (addr < `CPU20_NUM_REGS) ? regs[addr] : '0;
    endfunction

    always_comb rd_data1 = rd(rd_addr1);
    always_comb rd_data2 = rd(rd_addr2);
    always_comb dbg_data = rd(dbg_addr);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `CPU20_NUM_REGS; i++)
                regs[i] <= '0;
        end else begin
            if (load && load_allow && (load_addr < `CPU20_NUM_REGS))
                regs[load_addr] <= load_data;
            if (we1 && (wr_addr1 < `CPU20_NUM_REGS))
                regs[wr_addr1] <= wr_data1;
            if (we2 && (wr_addr2 < `CPU20_NUM_REGS))
                regs[wr_addr2] <= wr_data2;   // Last write wins on same address
        end
    end

    // Write-back and host load never share a cycle
    a_no_wb_in_fetch: assert property (@(posedge clk) disable iff (reset)
        (we1 || we2) |-> !load_allow);

endmodule

/* cpu20_sequencer.sv */
// Four-stage control FSM with instruction register and decode
// Operand, result and flag registers between stages, write-back strobes
`include "cpu20_macros.svh"

module cpu20_sequencer (
    input  logic                  clk,
    input  logic                  reset,
    input  cpu20_pkg::word_t      instruction,
    input  logic                  trap,
    output cpu20_pkg::reg_addr_t  rd_addr1,
    output cpu20_pkg::reg_addr_t  rd_addr2,
    input  cpu20_pkg::word_t      rd_data1,
    input  cpu20_pkg::word_t      rd_data2,
    cpu20_exec_if.seq             ex,
    output logic                  we1,
    output logic                  we2,
    output cpu20_pkg::reg_addr_t  wr_addr1,
    output cpu20_pkg::reg_addr_t  wr_addr2,
    output cpu20_pkg::word_t      wr_data1,
    output cpu20_pkg::word_t      wr_data2,
    output logic                  flag_we,
    output cpu20_pkg::flags_t     flag_val,
    output cpu20_pkg::flags_t     flag_mask,
    output logic                  trap_set,
    output logic                  fetch_enable,
    output logic                  decode_enable,
    output logic                  execute_enable,
    output logic                  write_back_enable
);

    cpu20_pkg::stage_t  state;
    cpu20_pkg::word_t   ir;          // Instruction register
    cpu20_pkg::opcode_t ir_op;
    cpu20_pkg::opcode_t op_q;        // Decoded opcode
    logic               half_q;      // Decoded mode bit
    cpu20_pkg::word_t   a_q, b_q;    // Operands
    cpu20_pkg::word_t   res1_q, res2_q;
    cpu20_pkg::flags_t  fval_q, fmask_q;
    logic               wr_dst1;     // Op writes dst1

    // Instruction fields
    assign ir_op    = cpu20_pkg::opcode_t'(ir[`CPU20_OPC_LSB +: `CPU20_OPCODE_W]);
    assign rd_addr1 = ir[`CPU20_SRC1_LSB +: `CPU20_REG_ADDR_W];
    assign rd_addr2 = ir[`CPU20_SRC2_LSB +: `CPU20_REG_ADDR_W];
    assign wr_addr1 = ir[`CPU20_DST1_LSB +: `CPU20_REG_ADDR_W];
    assign wr_addr2 = ir[`CPU20_DST2_LSB +: `CPU20_REG_ADDR_W];

    // Stage FSM parks in DECODE on TRAP
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= cpu20_pkg::FETCH_ST;
        end else begin
            case (state)
                cpu20_pkg::FETCH_ST:   state <= cpu20_pkg::DECODE_ST;
                cpu20_pkg::DECODE_ST: begin
                    if (ir_op != cpu20_pkg::TRAP_OP)
                        state <= cpu20_pkg::EXECUTE_ST;
                end
                cpu20_pkg::EXECUTE_ST: state <= cpu20_pkg::WRITE_BACK_ST;
                default:               state <= cpu20_pkg::FETCH_ST;
            endcase
        end
    end

    // Pipeline payload registers
    always_ff @(posedge clk) begin
        if (state == cpu20_pkg::FETCH_ST)
            ir <= instruction;           // Sampled at end of FETCH
        if (state == cpu20_pkg::DECODE_ST) begin
            op_q   <= ir_op;
            half_q <= ir[`CPU20_MODE_BIT];
            a_q    <= rd_data1;
            b_q    <= rd_data2;
        end
        if (state == cpu20_pkg::EXECUTE_ST) begin
            res1_q  <= ex.res1;          // ALU settled by now
            res2_q  <= ex.res2;
            fval_q  <= ex.flags_new;
            fmask_q <= ex.flag_mask;
        end
    end

    assign ex.op   = op_q;
    assign ex.half = half_q;
    assign ex.a    = a_q;
    assign ex.b    = b_q;

    // Ops with a dst1 result
    always_comb begin
        case (op_q)
            cpu20_pkg::NOT_OP, cpu20_pkg::AND_OP, cpu20_pkg::OR_OP,
            cpu20_pkg::XOR_OP, cpu20_pkg::SHFTR_OP, cpu20_pkg::SHFTL_OP,
            cpu20_pkg::ROTR_OP, cpu20_pkg::ROTL_OP, cpu20_pkg::SWAP_OP,
            cpu20_pkg::INC_OP, cpu20_pkg::DEC_OP: wr_dst1 = 1'b1;
            default:                              wr_dst1 = 1'b0;
        endcase
    end

    // Write-back strobes
    assign we1       = (state == cpu20_pkg::WRITE_BACK_ST) && wr_dst1;
    assign we2       = (state == cpu20_pkg::WRITE_BACK_ST) && (op_q == cpu20_pkg::SWAP_OP);
    assign wr_data1  = res1_q;
    assign wr_data2  = res2_q;
    assign flag_we   = (state == cpu20_pkg::WRITE_BACK_ST) && (|fmask_q);
    assign flag_val  = fval_q;
    assign flag_mask = fmask_q;

    // One pulse that the status block holds
    assign trap_set = (state == cpu20_pkg::DECODE_ST) && (ir_op == cpu20_pkg::TRAP_OP) && !trap;

    // Stage enables go dark once trapped
    assign fetch_enable      = (state == cpu20_pkg::FETCH_ST)      && !trap;
    assign decode_enable     = (state == cpu20_pkg::DECODE_ST)     && !trap;
    assign execute_enable    = (state == cpu20_pkg::EXECUTE_ST)    && !trap;
    assign write_back_enable = (state == cpu20_pkg::WRITE_BACK_ST) && !trap;

    // Trap from status block only while parked on a decoded TRAP
    a_trap_parked: assert property (@(posedge clk) disable iff (reset)
        trap |-> (state == cpu20_pkg::DECODE_ST) && (ir_op == cpu20_pkg::TRAP_OP));

endmodule

/* cpu20_status.sv */
// Zero, sign and carry flag register with masked update
// Sticky trap flag

module cpu20_status (
    input  logic               clk,
    input  logic               reset,
    input  logic               flag_we,
    input  cpu20_pkg::flags_t  flag_val,
    input  cpu20_pkg::flags_t  flag_mask,   // 1 = update this flag
    input  logic               trap_set,
    output cpu20_pkg::flags_t  flags,
    output logic               trap
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flags <= '0;
        end else if (flag_we) begin
            // Unmasked flags hold
            if (flag_mask.zero)
                flags.zero <= flag_val.zero;
            if (flag_mask.sign)
                flags.sign <= flag_val.sign;
            if (flag_mask.carry)
                flags.carry <= flag_val.carry;
        end
    end

    // Cleared only by reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            trap <= 1'b0;
        else if (trap_set)
            trap <= 1'b1;
    end

    // Sequencer must stop writing flags after a trap
    a_no_flag_write_trapped: assert property (@(posedge clk) disable iff (reset)
        flag_we |-> !trap);

endmodule

/* tb_cpu20_core.sv */
// Testbench for the cpu20 core with random instructions against a reference model
// Stage sequence, register and flag checks, unkept opcodes and TRAP, watchdog

module tb_cpu20_core;

    localparam int N_LOGIC   = 200;
    localparam int N_SWAP    = 40;
    localparam int N_CMP     = 60;
    localparam int N_UNKEPT  = 30;
    // Six NOP loads per test instruction
    // Then six loads and TRAP, whose 22-cycle window fits in six more slots
    localparam int TOTAL_INSTR = (N_LOGIC + N_SWAP + N_CMP + N_UNKEPT) * 7 + 6 + 6;

    logic        clk, reset, load;
    logic [19:0] instruction, load_data;
    logic [2:0]  load_addr, dbg_addr;
    wire  [19:0] dbg_data;
    wire         fetch_enable, decode_enable, execute_enable, write_back_enable;
    wire         zero_flag, sign_flag, carry_flag, trap_flag;

    integer      seed, errors, checks, seq_errs, instr_count, mark;
    logic [19:0] m_regs [0:5];    // Model registers
    logic        mz, ms, mc;      // Model flags
    logic [5:0]  logic_ops [0:9] = '{6'h08, 6'h09, 6'h0A, 6'h0B, 6'h0C,
                                     6'h0D, 6'h0E, 6'h0F, 6'h11, 6'h12};
    logic [5:0]  cmp_ops [0:4]   = '{6'h17, 6'h18, 6'h19, 6'h1A, 6'h1B};

    cpu20_core UUT (
        .clk, .reset, .instruction, .load, .load_addr, .load_data, .dbg_addr, .dbg_data,
        .fetch_enable, .decode_enable, .execute_enable, .write_back_enable,
        .zero_flag, .sign_flag, .carry_flag, .trap_flag
    );

    always #50 clk = ~clk;

    // Inputs change and outputs are sampled 10 units after the edge
    task next_cycle;
        @(posedge clk);
        #10;
    endtask

    task check_value(input string name, input logic [19:0] exp, input logic [19:0] act);
        checks++;
        if (act !== exp) begin
            $display("Error: %s expected %h got %h", name, exp, act);
            errors++;
        end
    endtask

    task check_enables(input logic [3:0] exp);
        checks++;
        if ({fetch_enable, decode_enable, execute_enable, write_back_enable} !== exp) begin
            $display("Error: enables {fetch,decode,execute,write_back} expected %h got %h",
                     exp, {fetch_enable, decode_enable, execute_enable, write_back_enable});
            errors++;
            seq_errs++;
        end
    endtask

    function automatic logic [19:0] model_read(input logic [2:0] a);
        return (a < 6) ? m_regs[a] : 20'h0;   // 6 and 7 unmapped
    endfunction

    task model_write(input logic [2:0] a, input logic [19:0] v);
        if (a < 6)
            m_regs[a] = v;
    endtask

    // Applies one instruction to the model registers and flags
    task model_apply(input logic [19:0] ins);
        logic [5:0]  op;
        logic [19:0] mask, top, am, bm, r;
        logic        wr;
        op   = ins[19:14];
        mask = ins[1] ? 20'h003FF : 20'hFFFFF;
        top  = ins[1] ? 20'h00200 : 20'h80000;   // MSB of active width
        am   = model_read(ins[13:11]) & mask;
        bm   = model_read(ins[10:8]) & mask;
        wr   = (op >= 6'h08) && (op <= 6'h12) && (op != 6'h10);   // Ops writing dst1
        r    = 20'h0;
        case (op)
            6'h08: r = ~am & mask;
            6'h09: r = am & bm;
            6'h0A: r = am | bm;
            6'h0B: r = am ^ bm;
            6'h0C: begin
                r  = am >> 1;
                mc = am[0];
            end
            6'h0D: begin
                r  = (am << 1) & mask;
                mc = |(am & top);
            end
            6'h0E: r = (am >> 1) | (am[0] ? top : 20'h0);
            6'h0F: r = ((am << 1) & mask) | {19'h0, |(am & top)};
            6'h10: begin
                model_write(ins[7:5], bm);
                model_write(ins[4:2], am);   // dst2 wins on a tie
            end
            6'h11: begin
                r  = (am + 20'h1) & mask;
                mc = (r == 20'h0);           // Wrapped to zero
            end
            6'h12: begin
                r  = (am - 20'h1) & mask;
                mc = (r == mask);            // Wrapped to all ones
            end
            6'h17: mz = (am == bm);
            6'h18: ms = (am > bm);
            6'h19: ms = (am < bm);
            6'h1A: begin
                ms = (am > bm);
                mz = (am == bm);
            end
            6'h1B: begin
                ms = (am < bm);
                mz = (am == bm);
            end
            default: ;                       // NOP, TRAP handled apart
        endcase
        if (wr) begin
            model_write(ins[7:5], r);
            if (op != 6'h0E && op != 6'h0F)
                mz = (r == 20'h0);           // Rotates keep all flags
        end
    endtask

    // Reads every register through dbg and compares flags
    task check_state(input logic exp_trap);
        for (int i = 0; i < 8; i++) begin
            dbg_addr = i[2:0];
            #1;
            check_value($sformatf("dbg_data[r%0d]", i), model_read(i[2:0]), dbg_data);
        end
        check_value("zero_flag", {19'h0, mz}, {19'h0, zero_flag});
        check_value("sign_flag", {19'h0, ms}, {19'h0, sign_flag});
        check_value("carry_flag", {19'h0, mc}, {19'h0, carry_flag});
        check_value("trap_flag", {19'h0, exp_trap}, {19'h0, trap_flag});
    endtask

    // One instruction through all four stages from FETCH
    task run_instr(input logic [19:0] ins, input logic ld, input logic [2:0] la,
                   input logic [19:0] ld_data);
        instruction = ins;
        load        = ld;
        load_addr   = la;
        load_data   = ld_data;
        next_cycle;
        load = 1'b0;
        check_enables(4'b0100);
        next_cycle;
        check_enables(4'b0010);
        next_cycle;
        check_enables(4'b0001);
        next_cycle;
        check_enables(4'b1000);   // Next FETCH follows
        instr_count++;
    endtask

    // One register per FETCH carried by NOPs
    task load_all_regs;
        logic [19:0] v;
        for (int r = 0; r < 6; r++) begin
            v = $random(seed);
            run_instr({6'h01, 14'h0}, 1'b1, r[2:0], v);
            m_regs[r] = v;
        end
    endtask

    task run_test_op(input logic [5:0] op, input logic same_dst, input logic same_src);
        logic [31:0] rnd;
        logic [19:0] ins;
        load_all_regs;
        rnd = $random(seed);
        ins = {op, rnd[13:0]};
        if (same_dst)
            ins[4:2] = ins[7:5];
        if (same_src)
            ins[10:8] = ins[13:11];   // Equal operands
        run_instr(ins, 1'b0, 3'd0, 20'h0);
        model_apply(ins);
        check_state(1'b0);
    endtask

    task pick_unkept(output logic [5:0] op);
        do
            op = $random(seed);
        while (op == 6'h00 || (op >= 6'h08 && op <= 6'h12) || (op >= 6'h17 && op <= 6'h1B));
    endtask

    task report_test(input int num, input string name);
        $display("Test %0d %s: %0d errors", num, name, errors - mark);
        mark = errors;
    endtask

    // Watchdog sized from the instruction count
    initial begin
        #(4 * 100 * TOTAL_INSTR + 2000);
        $display("Timeout: the run did not finish in the expected time");
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        logic [5:0]  op;
        logic [31:0] rnd;
        clk = 1'b0;
        reset = 1'b1;
        instruction = 20'h0;
        load = 1'b0;
        load_addr = 3'd0;
        load_data = 20'h0;
        dbg_addr = 3'd0;
        seed = 49082;
        {errors, checks, seq_errs, instr_count, mark} = '0;
        for (int i = 0; i < 6; i++)
            m_regs[i] = 20'h0;
        {mz, ms, mc} = 3'b000;

        repeat (3) @(posedge clk);
        #10 reset = 1'b0;
        check_enables(4'b1000);
        check_state(1'b0);
        report_test(1, "reset state");

        for (int i = 0; i < N_LOGIC; i++)
            run_test_op(logic_ops[$unsigned($random(seed)) % 10], 1'b0, 1'b0);
        report_test(3, "logic, shift, rotate, inc/dec");

        for (int i = 0; i < N_SWAP; i++)
            run_test_op(6'h10, (i % 4) == 0, 1'b0);
        report_test(4, "swap");

        for (int i = 0; i < N_CMP; i++)
            run_test_op(cmp_ops[$unsigned($random(seed)) % 5], 1'b0, (i % 3) == 0);
        report_test(5, "compares");

        for (int i = 0; i < N_UNKEPT; i++) begin
            pick_unkept(op);
            run_test_op(op, 1'b0, 1'b0);
        end
        load_all_regs;
        rnd = $random(seed);
        instruction = {6'h00, rnd[13:0]};   // TRAP
        next_cycle;
        check_enables(4'b0100);
        next_cycle;
        for (int i = 0; i < 20; i++) begin
            check_enables(4'b0000);
            check_value("trap_flag", 20'h1, {19'h0, trap_flag});
            load = (i == 5);                 // Load must be ignored
            load_addr = rnd[18:16] % 6;
            load_data = ~rnd[19:0];
            next_cycle;
        end
        load = 1'b0;
        check_state(1'b1);
        report_test(6, "unkept opcodes and trap");
        $display("Test 2 stage sequence over %0d instructions: %0d errors",
                 instr_count, seq_errs);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule
